// File: tb.f
+incdir+sim
hw/video_pkg.sv
hw/video_regs.sv
hw/video_timing.sv
hw/video_tilemap.sv
hw/video_colmix.sv
hw/video_top.sv
sim/tb_video.sv

// File: sim/tb_video_tests.svh
// video testbench directed tests and the expected image model
`ifndef TB_VIDEO_TESTS_SVH
`define TB_VIDEO_TESTS_SVH
`default_nettype none

logic [23:0] ref_frame [NPIX];

// one layer pixel at screen (x, y) from the map and ROM formulas
function automatic logic [3:0] layer_pixel(input int size, input logic [15:0] hpos,
        input logic [15:0] vpos, input logic [15:0] base, input int x, input int y);
    logic [15:0] wx;
    logic [15:0] wy;
    logic [22:0] code;
    logic [31:0] row_bits;
    int          wpr;
    wx       = hpos + 16'(x);
    wy       = vpos + 16'(y);
    wpr      = size / 8;
    code     = 23'(vram_word(23'(base) + 23'((wy / size) % 32 * MAP_COLS + (wx / size) % 32)));
    row_bits = rom_word(code * 23'(size * wpr) + 23'((wy % size) * wpr + (wx % size) / 8));
    return row_bits[4 * (wx % 8) +: 4];
endfunction

function automatic logic [23:0] expected_rgb(input int x, input int y);
    logic [3:0]  p1;
    logic [3:0]  p2;
    logic [4:0]  idx;
    logic [11:0] c;
    p1 = en1 ? layer_pixel(8, h1, v1, BASE1, x, y) : TRANSPARENT;
    p2 = en2 ? layer_pixel(16, h2, v2, BASE2, x, y) : TRANSPARENT;
    idx = 5'd15;
    if (p1 != TRANSPARENT) begin
        idx = {1'b0, p1};
    end else if (p2 != TRANSPARENT) begin
        idx = 5'd16 + 5'(p2);
    end
    c = pal_model[idx];
    return {c[11:8], c[11:8], c[7:4], c[7:4], c[3:0], c[3:0]};
endfunction

task automatic write_palette(input int index, input logic [11:0] rgb);
    pal_model[index] = rgb;
    apb_write(PAL_BASE + 12'(4 * index), {20'hfffff, rgb});
endtask

task automatic setup_layers(input logic e1, input logic e2, input logic [15:0] hp1,
        input logic [15:0] vp1, input logic [15:0] hp2, input logic [15:0] vp2);
    {en1, en2, h1, v1, h2, v2} = {e1, e2, hp1, vp1, hp2, vp2};
    apb_write(REG_HPOS1, 32'(hp1));
    apb_write(REG_VPOS1, 32'(vp1));
    apb_write(REG_HPOS2, 32'(hp2));
    apb_write(REG_VPOS2, 32'(vp2));
    apb_write(REG_BASE1, 32'(BASE1));
    apb_write(REG_BASE2, 32'(BASE2));
    apb_write(REG_LAYER_EN, {30'd0, e2, e1});
endtask

// the six 16-bit registers sit at consecutive words from 0x00
task automatic check_config_regs(input string test);
    logic [31:0] rd;
    for (int i = 0; i < 6; i++) begin
        apb_read(12'(4 * i), rd);
        check_eq(test, 32'(16'(i * 16'h1357 + 16'h0f0f)), rd);
        check_eq({test, " pslverr"}, 32'd0, 32'(last_err));
    end
    apb_read(REG_LAYER_EN, rd);
    check_eq({test, " layer enable"}, 32'd2, rd);
endtask

task automatic test_registers;
    logic [31:0] rd;
    for (int i = 0; i < 6; i++) begin
        apb_write(12'(4 * i), {16'hdead, 16'(i * 16'h1357 + 16'h0f0f)});
    end
    apb_write(REG_LAYER_EN, 32'hffff_fffe);
    check_config_regs("register readback");
    write_palette(3, 12'h7c1);
    apb_read(PAL_BASE + 12'h00c, rd);
    check_eq("palette read", 32'd0, rd);
    apb_write(12'h01c, 32'hffff_ffff);
    check_eq("unmapped write pslverr", 32'd1, 32'(last_err));
    apb_read(12'h200, rd);
    check_eq("unmapped read pslverr", 32'd1, 32'(last_err));
    check_config_regs("registers after unmapped write");
endtask

task automatic test_raster_timing;
    logic p_hs, p_vs, p_hb;
    int   guard, hs_ticks, lines, run, vis_lines;
    guard = 0;
    do begin
        p_vs = vs;
        next_tick();
        guard++;
        if (guard > TICK_LIMIT) begin
            fail_stop("timeout waiting for VS to rise");
        end
    end while (!(vs && !p_vs));
    {hs_ticks, lines, run, vis_lines} = '0;
    do begin
        {p_hs, p_vs, p_hb} = {hs, vs, hb};
        next_tick();
        guard++;
        if (guard > TICK_LIMIT) begin
            fail_stop("timeout waiting for the next VS rise");
        end
        hs_ticks++;
        if (hs && !p_hs) begin
            if (lines > 0) begin
                check_eq("ticks per line", H_TOTAL, hs_ticks);
            end
            lines++;
            hs_ticks = 0;
        end
        if (!hb && !vb) begin
            run++;
        end
        if (hb && !p_hb && run > 0) begin
            check_eq("visible pixels per line", H_VISIBLE, run);
            vis_lines++;
            run = 0;
        end
    end while (!(vs && !p_vs));
    check_eq("lines per frame", V_TOTAL, lines);
    check_eq("visible lines per frame", V_VISIBLE, vis_lines);
endtask

task automatic compare_frame(input string test);
    for (int n = 0; n < NPIX; n++) begin
        check_eq($sformatf("%s x=%0d y=%0d", test, n % H_VISIBLE, n / H_VISIBLE),
                 32'(expected_rgb(n % H_VISIBLE, n / H_VISIBLE)), 32'(frame[n]));
    end
endtask

task automatic test_backdrop;
    setup_layers(1'b0, 1'b0, 16'd0, 16'd0, 16'd0, 16'd0);
    write_palette(15, 12'h5a3);
    capture_frame();
    compare_frame("backdrop");
    check_eq("backdrop blanked pixels lit", 32'd0, blank_lit);
endtask

task automatic test_layer1;
    for (int i = 0; i < PAL_WORDS; i++) begin
        write_palette(i, pal_rgb(i));
    end
    setup_layers(1'b1, 1'b0, 16'd0, 16'd0, 16'd0, 16'd0);
    capture_frame();
    compare_frame("layer1 image");
endtask

task automatic test_scroll_priority;
    // layer 2 hpos wraps below zero
    setup_layers(1'b1, 1'b1, 16'd13, 16'd5, 16'hfff5, 16'd22);
    capture_frame();
    compare_frame("scroll and priority");
    check_eq("scroll blanked pixels lit", 32'd0, blank_lit);
    for (int n = 0; n < NPIX; n++) begin
        ref_frame[n] = frame[n];
    end
endtask

task automatic test_backpressure;
    @(posedge clk);
    jitter <= 1'b1;
    capture_frame();
    for (int n = 0; n < NPIX; n++) begin
        check_eq($sformatf("backpressure x=%0d y=%0d", n % H_VISIBLE, n / H_VISIBLE),
                 32'(ref_frame[n]), 32'(frame[n]));
    end
    @(posedge clk);
    jitter <= 1'b0;
endtask

`default_nettype wire
`endif

// File: sim/tb_video.sv
// video subsystem testbench with memory models, APB driver and frame capture
`default_nettype none
`timescale 1ns/1ns

module handshake_delay (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic cs,
    input  wire logic jitter,
    output logic      ok
);

int unsigned wait_left;

initial begin
    ok        = 1'b0;
    wait_left = 0;
end

// ok one cycle after cs, plus 0..3 extra cycles when jitter is on
always @(posedge clk) begin
    if (reset) begin
        ok        <= 1'b0;
        wait_left <= 0;
    end else if (cs && !ok) begin
        if (wait_left == 0) begin
            ok        <= 1'b1;
            wait_left <= jitter ? $urandom_range(3) : 0;
        end else begin
            wait_left <= wait_left - 1;
        end
    end else begin
        ok <= 1'b0;
    end
end

endmodule

module tb_video import video_pkg::*; ();

localparam int          NPIX       = H_VISIBLE * V_VISIBLE;
localparam int          TICK_LIMIT = 3 * H_TOTAL * V_TOTAL;
localparam logic [15:0] BASE1      = 16'h0000;
localparam logic [15:0] BASE2      = 16'h0400;

logic        clk, reset, cen8, jitter;
apb_req_t    apb_req;
apb_rsp_t    apb_rsp;
vram_req_t   vram1_req, vram2_req;
vram_rsp_t   vram1_rsp, vram2_rsp;
rom_req_t    rom1_req, rom2_req;
rom_rsp_t    rom1_rsp, rom2_rsp;
logic        ok_v1, ok_v2, ok_r1, ok_r2;
logic [15:0] data_v1, data_v2;
logic [31:0] data_r1, data_r2;
logic [7:0]  red, green, blue;
logic        hb, vb, hs, vs;
logic        last_err;
int          blank_lit;
int          rng_seed;
logic [23:0] frame [NPIX];

// what the registers and palette should hold
logic        en1, en2;
logic [15:0] h1, v1, h2, v2;
logic [11:0] pal_model [PAL_WORDS];

always #2 clk = ~clk;

always @(posedge clk) begin
    cen8 <= ~cen8;
end

// tile codes
function automatic logic [15:0] vram_word(input logic [22:0] addr);
    return 16'((addr * 7 + (addr / 32) * 3) % 61);
endfunction

// 8 pixels per word, roughly a third of them transparent
function automatic logic [31:0] rom_word(input logic [22:0] addr);
    logic [31:0] w;
    int          n;
    for (int i = 0; i < 8; i++) begin
        n = (addr * 5 + i * 3 + addr / 16) % 21;
        w[4*i +: 4] = (n > 14) ? 4'd15 : 4'(n);
    end
    return w;
endfunction

function automatic logic [11:0] pal_rgb(input int i);
    return 12'(i * 12'h1b7 + 12'h035);
endfunction

always @(posedge clk) begin
    data_v1 <= vram_word(vram1_req.addr);
    data_v2 <= vram_word(vram2_req.addr);
    data_r1 <= rom_word(rom1_req.addr);
    data_r2 <= rom_word(rom2_req.addr);
end

// half is the low word address bit of a 16-pixel row and stays 0 for 8x8 tiles
always @(posedge clk) begin
    if (rom1_req.cs) begin
        check_eq("rom1 half", 32'd0, 32'(rom1_req.half));
    end
    if (rom2_req.cs) begin
        check_eq("rom2 half", 32'(rom2_req.addr[0]), 32'(rom2_req.half));
    end
end

assign vram1_rsp = {ok_v1, data_v1};
assign vram2_rsp = {ok_v2, data_v2};
assign rom1_rsp  = {ok_r1, data_r1};
assign rom2_rsp  = {ok_r2, data_r2};

handshake_delay vram1_mem(.clk(clk), .reset(reset), .cs(vram1_req.cs), .jitter(jitter), .ok(ok_v1));
handshake_delay vram2_mem(.clk(clk), .reset(reset), .cs(vram2_req.cs), .jitter(jitter), .ok(ok_v2));
handshake_delay rom1_mem(.clk(clk), .reset(reset), .cs(rom1_req.cs), .jitter(jitter), .ok(ok_r1));
handshake_delay rom2_mem(.clk(clk), .reset(reset), .cs(rom2_req.cs), .jitter(jitter), .ok(ok_r2));

video_top DUT(
    .clk(clk), .reset(reset), .cen8(cen8),
    .apb_req(apb_req), .apb_rsp(apb_rsp),
    .vram1_req(vram1_req), .vram1_rsp(vram1_rsp),
    .rom1_req(rom1_req), .rom1_rsp(rom1_rsp),
    .vram2_req(vram2_req), .vram2_rsp(vram2_rsp),
    .rom2_req(rom2_req), .rom2_rsp(rom2_rsp),
    .red(red), .green(green), .blue(blue),
    .hb(hb), .vb(vb), .hs(hs), .vs(vs)
);

task automatic fail_stop(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
endtask

task automatic check_eq(input string test, input logic [31:0] expected,
                        input logic [31:0] actual);
    if (expected !== actual) begin
        fail_stop($sformatf("CHECK FAILED %s: expected %h, actual %h",
                            test, expected, actual));
    end
endtask

// lands on a negedge right after a pixel tick
task automatic next_tick;
    @(negedge clk);
    if (cen8) begin
        @(negedge clk);
    end
endtask

task automatic apb_access(input logic write, input logic [11:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata);
    int guard;
    @(posedge clk);
    // psel, penable, pwrite, paddr, pwdata
    apb_req <= {1'b1, 1'b0, write, addr, wdata};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    guard = 0;
    do begin
        @(negedge clk);
        guard++;
        if (guard > 16) begin
            fail_stop("timeout waiting for APB pready");
        end
    end while (!apb_rsp.pready);
    rdata    = apb_rsp.prdata;
    last_err = apb_rsp.pslverr;
    @(posedge clk);
    apb_req <= '0;
endtask

task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused);
endtask

task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
    apb_access(1'b0, addr, 32'd0, data);
endtask

task automatic capture_frame;
    int   guard;
    int   n;
    logic p_vb;
    guard = 0;
    // a full vertical blank first so setup changes cover every line
    do begin
        p_vb = vb;
        next_tick();
        guard++;
        if (guard > TICK_LIMIT) begin
            fail_stop("timeout waiting for VB to rise");
        end
    end while (!(vb && !p_vb));
    do begin
        next_tick();
        guard++;
        if (guard > TICK_LIMIT) begin
            fail_stop("timeout waiting for VB to fall");
        end
    end while (vb);
    n         = 0;
    blank_lit = 0;
    while (n < NPIX) begin
        if (!hb && !vb) begin
            frame[n] = {red, green, blue};
            n++;
        end else if ({red, green, blue} != 24'd0) begin
            blank_lit++;
        end
        if (n < NPIX) begin
            next_tick();
            guard++;
            if (guard > TICK_LIMIT) begin
                fail_stop("timeout while capturing the visible frame");
            end
        end
    end
endtask

`include "tb_video_tests.svh"

initial begin
    rng_seed = $urandom(32'h436f4d39);
    clk      = 1'b0;
    reset    = 1'b1;
    cen8     = 1'b0;
    jitter   = 1'b0;
    apb_req  = '0;
    data_v1  = '0;
    data_v2  = '0;
    data_r1  = '0;
    data_r2  = '0;
    for (int i = 0; i < PAL_WORDS; i++) begin
        pal_model[i] = '0;
    end
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_eq("after reset", 32'd0, {apb_rsp.pready, apb_rsp.pslverr, vram1_req.cs,
             rom1_req.cs, vram2_req.cs, rom2_req.cs, hs, vs});
    test_registers();
    test_raster_timing();
    test_backdrop();
    test_layer1();
    test_scroll_priority();
    test_backpressure();
    $display("*** TEST PASSED ***");
    $finish;
end

endmodule

`default_nettype wire

// File: hw/video_top.sv
// video subsystem top, registers, timing, two scroll layers and colour mixer
`default_nettype none
`timescale 1ns/1ns

module video_top import video_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       cen8,
    input  wire apb_req_t   apb_req,
    output apb_rsp_t        apb_rsp,
    output vram_req_t       vram1_req,
    input  wire vram_rsp_t  vram1_rsp,
    output rom_req_t        rom1_req,
    input  wire rom_rsp_t   rom1_rsp,
    output vram_req_t       vram2_req,
    input  wire vram_rsp_t  vram2_rsp,
    output rom_req_t        rom2_req,
    input  wire rom_rsp_t   rom2_rsp,
    output logic [7:0]      red,
    output logic [7:0]      green,
    output logic [7:0]      blue,
    output logic            hb,
    output logic            vb,
    output logic            hs,
    output logic            vs
);

raster_t    raster;
layer_cfg_t layer1;
layer_cfg_t layer2;
pal_wr_t    pal_wr;
logic [3:0] pxl1;
logic [3:0] pxl2;

video_regs u_regs(
    .clk        ( clk           ),
    .reset      ( reset         ),
    .apb_req    ( apb_req       ),
    .apb_rsp    ( apb_rsp       ),
    .layer1     ( layer1        ),
    .layer2     ( layer2        ),
    .pal_wr     ( pal_wr        )
);

video_timing u_timing(
    .clk        ( clk           ),
    .reset      ( reset         ),
    .cen8       ( cen8          ),
    .raster     ( raster        )
);

// 8x8 tiles
video_tilemap #(.SIZE(8)) u_scroll1(
    .clk        ( clk           ),
    .reset      ( reset         ),
    .cen8       ( cen8          ),
    .raster     ( raster        ),
    .cfg        ( layer1        ),
    .vram_req   ( vram1_req     ),
    .vram_rsp   ( vram1_rsp     ),
    .rom_req    ( rom1_req      ),
    .rom_rsp    ( rom1_rsp      ),
    .pxl        ( pxl1          )
);

// 16x16 tiles
video_tilemap #(.SIZE(16)) u_scroll2(
    .clk        ( clk           ),
    .reset      ( reset         ),
    .cen8       ( cen8          ),
    .raster     ( raster        ),
    .cfg        ( layer2        ),
    .vram_req   ( vram2_req     ),
    .vram_rsp   ( vram2_rsp     ),
    .rom_req    ( rom2_req      ),
    .rom_rsp    ( rom2_rsp      ),
    .pxl        ( pxl2          )
);

video_colmix u_colmix(
    .clk        ( clk           ),
    .reset      ( reset         ),
    .cen8       ( cen8          ),
    .raster     ( raster        ),
    .en1        ( layer1.en     ),
    .en2        ( layer2.en     ),
    .pxl1       ( pxl1          ),
    .pxl2       ( pxl2          ),
    .pal_wr     ( pal_wr        ),
    .red        ( red           ),
    .green      ( green         ),
    .blue       ( blue          ),
    .hb         ( hb            ),
    .vb         ( vb            ),
    .hs         ( hs            ),
    .vs         ( vs            )
);

endmodule

`default_nettype wire

// File: hw/video_colmix.sv
// video colour mixer, palette lookup with fixed layer priority and aligned sync
`default_nettype none
`timescale 1ns/1ns

module video_colmix import video_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       cen8,
    input  wire raster_t    raster,
    input  wire logic       en1,
    input  wire logic       en2,
    input  wire logic [3:0] pxl1,
    input  wire logic [3:0] pxl2,
    input  wire pal_wr_t    pal_wr,
    output logic [7:0]      red,
    output logic [7:0]      green,
    output logic [7:0]      blue,
    output logic            hb,
    output logic            vb,
    output logic            hs,
    output logic            vs
);

logic [11:0] pal [PAL_WORDS];
logic [4:0]  idx;
logic [11:0] col;
// hb, vb, hs, vs one tick behind the raster
logic [3:0]  sync_d1;

// layer 1 on top, then layer 2, then backdrop
always_comb begin
    if (en1 && pxl1 != TRANSPARENT) begin
        idx = {1'b0, pxl1};
    end else if (en2 && pxl2 != TRANSPARENT) begin
        idx = {1'b1, pxl2};
    end else begin
        idx = {1'b0, TRANSPARENT};
    end
end

assign col = pal[idx];

always_ff @(posedge clk) begin
    if (reset) begin
        for (int i = 0; i < PAL_WORDS; i++) begin
            pal[i] <= '0;
        end
    end else if (pal_wr.we) begin
        pal[pal_wr.index] <= pal_wr.rgb;
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        sync_d1 <= '0;
        {hb, vb, hs, vs} <= '0;
        red   <= '0;
        green <= '0;
        blue  <= '0;
    end else if (cen8) begin
        sync_d1 <= {raster.hb, raster.vb, raster.hs, raster.vs};
        {hb, vb, hs, vs} <= sync_d1;
        // black during blanking, nibbles repeated to 8 bits
        if (sync_d1[3] || sync_d1[2]) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else begin
            red   <= {col[11:8], col[11:8]};
            green <= {col[7:4], col[7:4]};
            blue  <= {col[3:0], col[3:0]};
        end
    end
end

endmodule

`default_nettype wire

// File: hw/video_tilemap.sv
// video tilemap layer, fetches map and ROM rows into a double-banked line buffer
`default_nettype none
`timescale 1ns/1ns

module video_tilemap import video_pkg::*; #(
    parameter int SIZE = 8
) (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       cen8,
    input  wire raster_t    raster,
    input  wire layer_cfg_t cfg,
    output vram_req_t       vram_req,
    input  wire vram_rsp_t  vram_rsp,
    output rom_req_t        rom_req,
    input  wire rom_rsp_t   rom_rsp,
    output logic [3:0]      pxl
);

localparam int SH   = $clog2(SIZE);
// 32-bit ROM words per tile row
localparam int WPR  = SIZE / 8;
// 8-pixel columns covering the visible width at any scroll
localparam int COLS = H_VISIBLE / 8 + 1;
localparam int XW   = $clog2(H_VISIBLE);

fetch_state_t state;
logic         front;
logic [3:0]   col_cnt;
logic         start_tick;
logic         rd_bank;

// line values latched at start
logic [15:0]  colx;
logic [15:0]  hpos_l;
logic [15:0]  wy;
logic [15:0]  base_l;
logic [15:0]  code;

logic [4:0]    map_row;
logic [4:0]    map_col;
logic [SH-1:0] tile_row;
logic          half;
logic [15:0]   wr_x [8];

logic [3:0] line_buf [2][H_VISIBLE];

assign start_tick = cen8 & raster.start;

assign map_row  = wy[SH+4:SH];
assign map_col  = colx[SH+4:SH];
assign tile_row = wy[SH-1:0];
assign half     = (SIZE == 16) ? colx[3] : 1'b0;

assign vram_req.cs   = state == MAP_RD;
assign vram_req.addr = 23'(base_l) + 23'(map_row) * 23'(MAP_COLS) + 23'(map_col);

assign rom_req.cs   = state == ROM_RD;
assign rom_req.half = half;
assign rom_req.addr = 23'(code) * 23'(SIZE * WPR) + 23'(tile_row) * 23'(WPR) + 23'(half);

// fetch sequencer, restarts on every line begin
always_ff @(posedge clk) begin
    if (reset) begin
        state   <= IDLE;
        front   <= 1'b0;
        col_cnt <= '0;
    end else if (start_tick) begin
        front   <= ~front;
        col_cnt <= '0;
        state   <= cfg.en ? MAP_RD : IDLE;
    end else begin
        case (state)
            MAP_RD: if (vram_rsp.ok) state <= ROM_RD;
            ROM_RD: if (rom_rsp.ok) state <= NEXT;
            NEXT: begin
                col_cnt <= col_cnt + 4'd1;
                state   <= (col_cnt == 4'(COLS - 1)) ? IDLE : MAP_RD;
            end
            IDLE: ;
            default: state <= IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (start_tick) begin
        hpos_l <= cfg.hpos;
        colx   <= {cfg.hpos[15:3], 3'd0};
        wy     <= 16'(raster.vrender) + cfg.vpos;
        base_l <= cfg.vram_base;
    end else if (state == NEXT) begin
        colx <= colx + 16'd8;
    end
    if (state == MAP_RD && vram_rsp.ok) begin
        code <= vram_rsp.data;
    end
end

// screen x of each nibble, off-screen values wrap high
always_comb begin
    for (int i = 0; i < 8; i++) begin
        wr_x[i] = colx + 16'(i) - hpos_l;
    end
end

always_ff @(posedge clk) begin
    if (start_tick) begin
        // bank about to be filled starts out transparent
        for (int i = 0; i < H_VISIBLE; i++) begin
            line_buf[front][i] <= TRANSPARENT;
        end
    end else if (state == ROM_RD && rom_rsp.ok) begin
        for (int i = 0; i < 8; i++) begin
            if (wr_x[i] < 16'(H_VISIBLE)) begin
                line_buf[~front][wr_x[i][XW-1:0]] <= rom_rsp.data[4*i +: 4];
            end
        end
    end
end

// display side follows the swap in the same tick
assign rd_bank = start_tick ? ~front : front;

always_ff @(posedge clk) begin
    if (reset) begin
        pxl <= TRANSPARENT;
    end else if (cen8) begin
        if (raster.hdump < 9'(H_VISIBLE)) begin
            pxl <= line_buf[rd_bank][raster.hdump[XW-1:0]];
        end else begin
            pxl <= TRANSPARENT;
        end
    end
end

endmodule

`default_nettype wire

// File: hw/video_timing.sv
// video timing generator, raster counters with blanking, sync and line start
`default_nettype none
`timescale 1ns/1ns

module video_timing import video_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   cen8,
    output raster_t     raster
);

logic [8:0] h_next;
logic [7:0] v_next;
raster_t    nxt;

// counter advance for the coming pixel tick
always_comb begin
    h_next = raster.hdump + 9'd1;
    v_next = raster.vdump;
    if (raster.hdump == 9'(H_TOTAL - 1)) begin
        h_next = '0;
        if (raster.vdump == 8'(V_TOTAL - 1)) begin
            v_next = '0;
        end else begin
            v_next = raster.vdump + 8'd1;
        end
    end
end

// everything derived from the next count so all fields move together
always_comb begin
    nxt.hdump = h_next;
    nxt.vdump = v_next;
    if (v_next == 8'(V_TOTAL - 1)) begin
        nxt.vrender = '0;
    end else begin
        nxt.vrender = v_next + 8'd1;
    end
    nxt.hb    = h_next >= 9'(H_VISIBLE);
    nxt.vb    = v_next >= 8'(V_VISIBLE);
    nxt.hs    = (h_next >= 9'(H_SYNC_START)) && (h_next < 9'(H_SYNC_END));
    nxt.vs    = (v_next >= 8'(V_SYNC_START)) && (v_next < 8'(V_SYNC_END));
    nxt.start = h_next == '0;
end

always_ff @(posedge clk) begin
    if (reset) begin
        raster.hdump   <= '0;
        raster.vdump   <= '0;
        raster.vrender <= 8'd1;
        raster.hb      <= 1'b0;
        raster.vb      <= 1'b0;
        raster.hs      <= 1'b0;
        raster.vs      <= 1'b0;
        // hdump is zero out of reset, so a line begins here
        raster.start   <= 1'b1;
    end else if (cen8) begin
        raster <= nxt;
    end
end

endmodule

`default_nettype wire

// File: hw/video_regs.sv
// video register block, APB slave for layer setup and palette writes
`default_nettype none
`timescale 1ns/1ns

module video_regs import video_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire apb_req_t   apb_req,
    output apb_rsp_t        apb_rsp,
    output layer_cfg_t      layer1,
    output layer_cfg_t      layer2,
    output pal_wr_t         pal_wr
);

logic        access;
logic        wr_en;
logic        pal_hit;
logic        reg_hit;
logic [31:0] rdata;

assign access = apb_req.psel & apb_req.penable;
assign wr_en  = access & apb_req.pwrite;

// palette words sit in their own window, word aligned only
assign pal_hit = (apb_req.paddr >= PAL_BASE) &&
                 (apb_req.paddr < PAL_BASE + 12'(4 * PAL_WORDS)) &&
                 (apb_req.paddr[1:0] == 2'b00);

always_comb begin
    rdata   = '0;
    reg_hit = 1'b1;
    case (apb_req.paddr)
        REG_HPOS1:    rdata = 32'(layer1.hpos);
        REG_VPOS1:    rdata = 32'(layer1.vpos);
        REG_HPOS2:    rdata = 32'(layer2.hpos);
        REG_VPOS2:    rdata = 32'(layer2.vpos);
        REG_BASE1:    rdata = 32'(layer1.vram_base);
        REG_BASE2:    rdata = 32'(layer2.vram_base);
        REG_LAYER_EN: rdata = {30'd0, layer2.en, layer1.en};
        // palette reads back as zero
        default:      reg_hit = 1'b0;
    endcase
end

assign apb_rsp.pready  = access;
assign apb_rsp.pslverr = access & ~(reg_hit | pal_hit);
assign apb_rsp.prdata  = rdata;

always_ff @(posedge clk) begin
    if (reset) begin
        layer1 <= '0;
        layer2 <= '0;
        pal_wr <= '0;
    end else begin
        // palette entries live in the mixer, pass writes on as a pulse
        pal_wr.we    <= wr_en & pal_hit;
        pal_wr.index <= apb_req.paddr[6:2];
        pal_wr.rgb   <= apb_req.pwdata[11:0];
        if (wr_en) begin
            case (apb_req.paddr)
                REG_HPOS1: layer1.hpos      <= apb_req.pwdata[15:0];
                REG_VPOS1: layer1.vpos      <= apb_req.pwdata[15:0];
                REG_HPOS2: layer2.hpos      <= apb_req.pwdata[15:0];
                REG_VPOS2: layer2.vpos      <= apb_req.pwdata[15:0];
                REG_BASE1: layer1.vram_base <= apb_req.pwdata[15:0];
                REG_BASE2: layer2.vram_base <= apb_req.pwdata[15:0];
                REG_LAYER_EN: begin
                    layer1.en <= apb_req.pwdata[0];
                    layer2.en <= apb_req.pwdata[1];
                end
                default: ;
            endcase
        end
    end
end

endmodule

`default_nettype wire

// File: hw/video_pkg.sv
// video package with raster constants, register map and shared bus types
`default_nettype none

package video_pkg;

    // raster geometry in pixel ticks and lines
    localparam int H_TOTAL      = 80;
    localparam int H_VISIBLE    = 64;
    localparam int H_SYNC_START = 68;
    localparam int H_SYNC_END   = 72;
    localparam int V_TOTAL      = 48;
    localparam int V_VISIBLE    = 32;
    localparam int V_SYNC_START = 38;
    localparam int V_SYNC_END   = 40;

    // 32x32 tile map, coordinates wrap
    localparam int MAP_COLS = 32;

    // pixel value that lets the lower layer through
    localparam logic [3:0] TRANSPARENT = 4'd15;

    // register map, byte offsets of 32-bit words
    localparam logic [11:0] REG_HPOS1    = 12'h000;
    localparam logic [11:0] REG_VPOS1    = 12'h004;
    localparam logic [11:0] REG_HPOS2    = 12'h008;
    localparam logic [11:0] REG_VPOS2    = 12'h00C;
    localparam logic [11:0] REG_BASE1    = 12'h010;
    localparam logic [11:0] REG_BASE2    = 12'h014;
    localparam logic [11:0] REG_LAYER_EN = 12'h018;
    localparam logic [11:0] PAL_BASE     = 12'h100;
    localparam int          PAL_WORDS    = 32;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_t;

    // one scroll layer's setup
    typedef struct packed {
        logic        en;
        logic [15:0] hpos;
        logic [15:0] vpos;
        logic [15:0] vram_base;
    } layer_cfg_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  index;
        logic [11:0] rgb;
    } pal_wr_t;

    typedef struct packed {
        logic [8:0] hdump;
        logic [7:0] vdump;
        logic [7:0] vrender;
        logic       hb;
        logic       vb;
        logic       hs;
        logic       vs;
        logic       start;
    } raster_t;

    typedef struct packed {
        logic        cs;
        logic [22:0] addr;
    } vram_req_t;

    typedef struct packed {
        logic        ok;
        logic [15:0] data;
    } vram_rsp_t;

    typedef struct packed {
        logic        cs;
        logic [22:0] addr;
        logic        half;
    } rom_req_t;

    typedef struct packed {
        logic        ok;
        logic [31:0] data;
    } rom_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        MAP_RD,
        ROM_RD,
        NEXT
    } fetch_state_t;

endpackage

`default_nettype wire
